// File: filelist.f
source/rooth_pkg.sv
source/wb_stage_reg.sv
source/reg_file.sv
source/csr_file.sv
source/wb_subsys.sv
verif/tb_wb_subsys.sv

// File: run.sh
#!/bin/sh
# Build and run the writeback testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_subsys \
    -f filelist.f --Mdir obj_dir -o sim_wb_subsys || exit 1
sim_out="$(./obj_dir/sim_wb_subsys)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/tb_wb_subsys.sv
`default_nettype none

module tb_wb_subsys;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES   = 400;
    localparam int DRAIN_CYCLES = 4;
    // Margin of one half over the full stimulus length
    localparam int CYCLE_LIMIT  = (RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES) * 3 / 2;

    logic                                 clk;
    logic                                 rst_n;
    rooth_pkg::flow_e                     flow_wb_i;
    logic [rooth_pkg::CPU_WIDTH-1:0]      inst_i, pc_i;
    logic                                 reg_wr_en_i, csr_wr_en_i;
    logic [rooth_pkg::REG_ADDR_WIDTH-1:0] reg_wr_addr_i, rs1_addr_i, rs2_addr_i;
    logic [rooth_pkg::CSR_ADDR_WIDTH-1:0] csr_wr_addr_i, csr_rd_addr_i;
    logic [rooth_pkg::CPU_WIDTH-1:0]      reg_wr_data_i, csr_wr_data_i;
    logic [rooth_pkg::CPU_WIDTH-1:0]      inst_o, pc_o, rs1_data_o, rs2_data_o, csr_rd_data_o;

    // Model of the stage contents and of the committed state
    logic [rooth_pkg::CPU_WIDTH-1:0]      m_inst, m_pc, m_reg_data, m_csr_data;
    logic                                 m_reg_en, m_csr_en, m_retire;
    logic [rooth_pkg::REG_ADDR_WIDTH-1:0] m_reg_addr;
    logic [rooth_pkg::CSR_ADDR_WIDTH-1:0] m_csr_addr;
    logic [rooth_pkg::CPU_WIDTH-1:0]      shadow_regs [rooth_pkg::REG_COUNT];
    logic [rooth_pkg::CPU_WIDTH-1:0]      shadow_csr [5];
    logic [rooth_pkg::CPU_WIDTH-1:0]      retire_cnt;
    logic [rooth_pkg::CPU_WIDTH-1:0]      exp_rs1, exp_rs2, exp_csr;

    logic [31:0] lfsr_q;
    int          errors = 0;
    int          cycles = 0;

    wb_subsys i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .flow_wb_i     (flow_wb_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .reg_wr_en_i   (reg_wr_en_i),
        .reg_wr_addr_i (reg_wr_addr_i),
        .reg_wr_data_i (reg_wr_data_i),
        .csr_wr_en_i   (csr_wr_en_i),
        .csr_wr_addr_i (csr_wr_addr_i),
        .csr_wr_data_i (csr_wr_data_i),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .rs1_addr_i    (rs1_addr_i),
        .rs1_data_o    (rs1_data_o),
        .rs2_addr_i    (rs2_addr_i),
        .rs2_data_o    (rs2_data_o),
        .csr_rd_addr_i (csr_rd_addr_i),
        .csr_rd_data_o (csr_rd_data_o)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Six implemented CSRs and two that do not exist
    function automatic logic [11:0] csr_pick(input logic [2:0] sel);
        logic [11:0] table_q [8];
        table_q = '{rooth_pkg::CSR_MSTATUS, rooth_pkg::CSR_MTVEC, rooth_pkg::CSR_MSCRATCH,
                    rooth_pkg::CSR_MEPC, rooth_pkg::CSR_MCAUSE, rooth_pkg::CSR_MINSTRET,
                    12'h7C0, 12'hF14};
        return table_q[sel];
    endfunction

    // 0 to 4 plain CSRs, 5 minstret, -1 unknown
    function automatic int csr_index(input logic [11:0] addr);
        case (addr)
            rooth_pkg::CSR_MSTATUS:  return 0;
            rooth_pkg::CSR_MTVEC:    return 1;
            rooth_pkg::CSR_MSCRATCH: return 2;
            rooth_pkg::CSR_MEPC:     return 3;
            rooth_pkg::CSR_MCAUSE:   return 4;
            rooth_pkg::CSR_MINSTRET: return 5;
            default:                 return -1;
        endcase
    endfunction

    function automatic logic [31:0] csr_stored_value(input logic [11:0] addr,
                                                     input logic [31:0] data);
        return (addr == rooth_pkg::CSR_MTVEC) ? (data & 32'hFFFF_FFFC) : data;
    endfunction

    function automatic logic [31:0] expected_reg(input logic [4:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (m_reg_en && (m_reg_addr == addr)) begin
            return m_reg_data;
        end
        return shadow_regs[addr];
    endfunction

    function automatic logic [31:0] expected_csr(input logic [11:0] addr);
        int idx;
        idx = csr_index(addr);
        if (m_csr_en && (csr_index(m_csr_addr) >= 0) && (m_csr_addr == addr)) begin
            return csr_stored_value(addr, m_csr_data);
        end
        if (idx == 5) begin
            return retire_cnt;
        end
        return (idx < 0) ? 32'h0 : shadow_csr[idx];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors = errors + 1;
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    endtask

    task automatic drive_idle_item();
        flow_wb_i   = rooth_pkg::FLOW_WORK;
        inst_i      = '0;
        pc_i        = '0;
        reg_wr_en_i = 1'b0;
        csr_wr_en_i = 1'b0;
    endtask

    task automatic drive_random_item();
        logic [31:0] v;
        take_bits(3, v);
        case (v[2:0])
            3'd4, 3'd5: flow_wb_i = rooth_pkg::FLOW_STOP;
            3'd6:       flow_wb_i = rooth_pkg::FLOW_REFRESH;
            3'd7:       flow_wb_i = rooth_pkg::flow_e'(2'b11);
            default:    flow_wb_i = rooth_pkg::FLOW_WORK;
        endcase
        // About one item in four is a bubble
        take_bits(2, v);
        inst_i = '0;
        if (v[1:0] != 2'b00) begin
            take_bits(32, inst_i);
        end
        take_bits(32, pc_i);
        take_bits(2, v);
        reg_wr_en_i = |v[1:0];
        take_bits(5, v);
        reg_wr_addr_i = v[4:0];
        take_bits(32, reg_wr_data_i);
        take_bits(1, v);
        csr_wr_en_i = v[0];
        take_bits(3, v);
        csr_wr_addr_i = csr_pick(v[2:0]);
        take_bits(32, csr_wr_data_i);
        // Half the reads target the pending write to reach the bypass
        take_bits(1, v);
        rs1_addr_i = m_reg_addr;
        if (!v[0]) begin
            take_bits(5, v);
            rs1_addr_i = v[4:0];
        end
        take_bits(5, v);
        rs2_addr_i = v[4:0];
        take_bits(1, v);
        csr_rd_addr_i = m_csr_addr;
        if (!v[0]) begin
            take_bits(3, v);
            csr_rd_addr_i = csr_pick(v[2:0]);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {m_inst, m_pc, m_reg_en, m_reg_addr, m_reg_data} <= '0;
            {m_csr_en, m_csr_addr, m_csr_data, m_retire}     <= '0;
            for (int i = 0; i < rooth_pkg::REG_COUNT; i++) begin
                shadow_regs[i] <= '0;
            end
            for (int i = 0; i < 5; i++) begin
                shadow_csr[i] <= '0;
            end
            retire_cnt <= '0;
        end else begin
            // Commit of the item currently held in the stage
            if (m_reg_en && (m_reg_addr != '0)) begin
                shadow_regs[m_reg_addr] <= m_reg_data;
            end
            if (m_csr_en && (csr_index(m_csr_addr) inside {[0:4]})) begin
                shadow_csr[csr_index(m_csr_addr)] <= csr_stored_value(m_csr_addr, m_csr_data);
            end
            if (m_csr_en && (m_csr_addr == rooth_pkg::CSR_MINSTRET)) begin
                retire_cnt <= m_csr_data;
            end else if (m_retire) begin
                retire_cnt <= retire_cnt + 32'd1;
            end
            case (flow_wb_i)
                rooth_pkg::FLOW_WORK: begin
                    {m_inst, m_pc, m_reg_en, m_reg_addr, m_reg_data} <=
                        {inst_i, pc_i, reg_wr_en_i, reg_wr_addr_i, reg_wr_data_i};
                    {m_csr_en, m_csr_addr, m_csr_data} <=
                        {csr_wr_en_i, csr_wr_addr_i, csr_wr_data_i};
                    m_retire <= (inst_i != '0);
                end
                rooth_pkg::FLOW_STOP: m_retire <= 1'b0;
                default: begin
                    {m_inst, m_pc, m_reg_en, m_reg_addr, m_reg_data} <= '0;
                    {m_csr_en, m_csr_addr, m_csr_data, m_retire}     <= '0;
                end
            endcase
        end
    end

    always_comb begin
        exp_rs1 = expected_reg(rs1_addr_i);
        exp_rs2 = expected_reg(rs2_addr_i);
        exp_csr = expected_csr(csr_rd_addr_i);
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_inst: assert property (@(posedge clk) disable iff (!rst_n) inst_o == m_inst)
        else report_mismatch("inst_o", $sampled(inst_o), $sampled(m_inst));
    a_pc: assert property (@(posedge clk) disable iff (!rst_n) pc_o == m_pc)
        else report_mismatch("pc_o", $sampled(pc_o), $sampled(m_pc));
    a_rs1: assert property (@(posedge clk) disable iff (!rst_n) rs1_data_o == exp_rs1)
        else report_mismatch("rs1_data_o", $sampled(rs1_data_o), $sampled(exp_rs1));
    a_rs2: assert property (@(posedge clk) disable iff (!rst_n) rs2_data_o == exp_rs2)
        else report_mismatch("rs2_data_o", $sampled(rs2_data_o), $sampled(exp_rs2));
    a_csr: assert property (@(posedge clk) disable iff (!rst_n) csr_rd_data_o == exp_csr)
        else report_mismatch("csr_rd_data_o", $sampled(csr_rd_data_o), $sampled(exp_csr));

    a_stop_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (flow_wb_i == rooth_pkg::FLOW_STOP) |=> (inst_o == $past(inst_o)))
        else report_mismatch("inst_o held", $sampled(inst_o), $sampled(m_inst));
    a_refresh_inst: assert property (@(posedge clk) disable iff (!rst_n)
        !(flow_wb_i inside {rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_STOP}) |=> (inst_o == '0))
        else report_mismatch("inst_o after refresh", $sampled(inst_o), 32'h0);
    a_refresh_pc: assert property (@(posedge clk) disable iff (!rst_n)
        !(flow_wb_i inside {rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_STOP}) |=> (pc_o == '0))
        else report_mismatch("pc_o after refresh", $sampled(pc_o), 32'h0);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        lfsr_q = 32'd88976;
        drive_idle_item();
        {reg_wr_addr_i, reg_wr_data_i, csr_wr_addr_i, csr_wr_data_i} = '0;
        {rs1_addr_i, rs2_addr_i} = '0;
        // Counter register, so the read depends on the reset of real storage
        csr_rd_addr_i = rooth_pkg::CSR_MINSTRET;
        repeat (RESET_CYCLES) @(negedge clk);
        assert (inst_o == '0) else report_mismatch("inst_o at reset", inst_o, 32'h0);
        assert (pc_o == '0) else report_mismatch("pc_o at reset", pc_o, 32'h0);
        assert (csr_rd_data_o == '0)
            else report_mismatch("csr_rd_data_o minstret at reset", csr_rd_data_o, 32'h0);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random_item();
            @(negedge clk);
        end
        // Let the last item commit, then read back the instruction count
        repeat (DRAIN_CYCLES) begin
            drive_idle_item();
            @(negedge clk);
        end
        csr_rd_addr_i = rooth_pkg::CSR_MINSTRET;
        #1;
        assert (csr_rd_data_o == retire_cnt)
            else report_mismatch("csr_rd_data_o minstret", csr_rd_data_o, retire_cnt);
        @(negedge clk);
        $display("Run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/wb_subsys.sv
`default_nettype none

module wb_subsys (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire rooth_pkg::flow_e                       flow_wb_i,

    // Item from the memory stage
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              inst_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              pc_i,
    input  wire                                         reg_wr_en_i,
    input  wire [rooth_pkg::REG_ADDR_WIDTH-1:0]         reg_wr_addr_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              reg_wr_data_i,
    input  wire                                         csr_wr_en_i,
    input  wire [rooth_pkg::CSR_ADDR_WIDTH-1:0]         csr_wr_addr_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              csr_wr_data_i,

    // Trace
    output logic [rooth_pkg::CPU_WIDTH-1:0]             inst_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             pc_o,

    // Read ports
    input  wire [rooth_pkg::REG_ADDR_WIDTH-1:0]         rs1_addr_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             rs1_data_o,
    input  wire [rooth_pkg::REG_ADDR_WIDTH-1:0]         rs2_addr_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             rs2_data_o,
    input  wire [rooth_pkg::CSR_ADDR_WIDTH-1:0]         csr_rd_addr_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             csr_rd_data_o
);

    logic                                reg_wr_en;
    logic [rooth_pkg::REG_ADDR_WIDTH-1:0] reg_wr_addr;
    logic [rooth_pkg::CPU_WIDTH-1:0]     reg_wr_data;
    logic                                csr_wr_en;
    logic [rooth_pkg::CSR_ADDR_WIDTH-1:0] csr_wr_addr;
    logic [rooth_pkg::CPU_WIDTH-1:0]     csr_wr_data;
    logic                                retire;

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------

    wb_stage_reg i_wb_stage_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .flow_wb_i     (flow_wb_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .reg_wr_en_i   (reg_wr_en_i),
        .reg_wr_addr_i (reg_wr_addr_i),
        .reg_wr_data_i (reg_wr_data_i),
        .csr_wr_en_i   (csr_wr_en_i),
        .csr_wr_addr_i (csr_wr_addr_i),
        .csr_wr_data_i (csr_wr_data_i),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .reg_wr_en_o   (reg_wr_en),
        .reg_wr_addr_o (reg_wr_addr),
        .reg_wr_data_o (reg_wr_data),
        .csr_wr_en_o   (csr_wr_en),
        .csr_wr_addr_o (csr_wr_addr),
        .csr_wr_data_o (csr_wr_data),
        .retire_o      (retire)
    );

    // ----------------------------------------
    // Architectural state
    // ----------------------------------------

    reg_file i_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en_i    (reg_wr_en),
        .wr_addr_i  (reg_wr_addr),
        .wr_data_i  (reg_wr_data),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

    csr_file i_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (csr_wr_en),
        .wr_addr_i (csr_wr_addr),
        .wr_data_i (csr_wr_data),
        .retire_i  (retire),
        .rd_addr_i (csr_rd_addr_i),
        .rd_data_o (csr_rd_data_o)
    );

endmodule

`default_nettype wire

// File: source/csr_file.sv
`default_nettype none

module csr_file (
    input  wire                                         clk,
    input  wire                                         rst_n,

    input  wire                                         wr_en_i,
    input  wire [rooth_pkg::CSR_ADDR_WIDTH-1:0]         wr_addr_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              wr_data_i,
    input  wire                                         retire_i,

    input  wire [rooth_pkg::CSR_ADDR_WIDTH-1:0]         rd_addr_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             rd_data_o
);

    logic [rooth_pkg::CPU_WIDTH-1:0] mstatus_q;
    logic [rooth_pkg::CPU_WIDTH-1:0] mtvec_q;
    logic [rooth_pkg::CPU_WIDTH-1:0] mscratch_q;
    logic [rooth_pkg::CPU_WIDTH-1:0] mepc_q;
    logic [rooth_pkg::CPU_WIDTH-1:0] mcause_q;
    logic [rooth_pkg::CPU_WIDTH-1:0] minstret_q;

    logic                            wr_known;
    logic [rooth_pkg::CPU_WIDTH-1:0] wr_val;
    logic [rooth_pkg::CPU_WIDTH-1:0] rd_stored;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------

    always_comb begin
        wr_known = 1'b1;
        wr_val   = wr_data_i;
        case (wr_addr_i)
            rooth_pkg::CSR_MSTATUS,
            rooth_pkg::CSR_MSCRATCH,
            rooth_pkg::CSR_MEPC,
            rooth_pkg::CSR_MCAUSE,
            rooth_pkg::CSR_MINSTRET: wr_val = wr_data_i;
            // Vector base is word aligned, mode bits kept at direct
            rooth_pkg::CSR_MTVEC:    wr_val = {wr_data_i[rooth_pkg::CPU_WIDTH-1:2], 2'b00};
            default:                 wr_known = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (wr_en_i) begin
            case (wr_addr_i)
                rooth_pkg::CSR_MSTATUS:  mstatus_q  <= wr_val;
                rooth_pkg::CSR_MTVEC:    mtvec_q    <= wr_val;
                rooth_pkg::CSR_MSCRATCH: mscratch_q <= wr_val;
                rooth_pkg::CSR_MEPC:     mepc_q     <= wr_val;
                rooth_pkg::CSR_MCAUSE:   mcause_q   <= wr_val;
                default: ;
            endcase
        end
    end

    // Explicit write takes priority over the retire increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minstret_q <= '0;
        end else if (wr_en_i && (wr_addr_i == rooth_pkg::CSR_MINSTRET)) begin
            minstret_q <= wr_val;
        end else if (retire_i) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    always_comb begin
        case (rd_addr_i)
            rooth_pkg::CSR_MSTATUS:  rd_stored = mstatus_q;
            rooth_pkg::CSR_MTVEC:    rd_stored = mtvec_q;
            rooth_pkg::CSR_MSCRATCH: rd_stored = mscratch_q;
            rooth_pkg::CSR_MEPC:     rd_stored = mepc_q;
            rooth_pkg::CSR_MCAUSE:   rd_stored = mcause_q;
            rooth_pkg::CSR_MINSTRET: rd_stored = minstret_q;
            default:                 rd_stored = '0;
        endcase
    end

    // Bypass only for implemented addresses
    assign rd_data_o = (wr_en_i && wr_known && (rd_addr_i == wr_addr_i)) ? wr_val : rd_stored;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_mtvec_align: assert property (@(posedge clk) disable iff (!rst_n)
        mtvec_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                                         clk,
    input  wire                                         rst_n,

    input  wire                                         wr_en_i,
    input  wire [rooth_pkg::REG_ADDR_WIDTH-1:0]         wr_addr_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              wr_data_i,

    input  wire [rooth_pkg::REG_ADDR_WIDTH-1:0]         rs1_addr_i,
    input  wire [rooth_pkg::REG_ADDR_WIDTH-1:0]         rs2_addr_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             rs1_data_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             rs2_data_o
);

    logic [rooth_pkg::CPU_WIDTH-1:0] regs_q [rooth_pkg::REG_COUNT];
    logic                            wr_act;

    // x0 is never written
    assign wr_act = wr_en_i && (wr_addr_i != '0);

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rooth_pkg::REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_act) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------

    // Zero register, then write-through, then storage
    function automatic logic [rooth_pkg::CPU_WIDTH-1:0] read_port(
        input logic [rooth_pkg::REG_ADDR_WIDTH-1:0] addr
    );
        logic [rooth_pkg::CPU_WIDTH-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_act && (wr_addr_i == addr)) begin
            data = wr_data_i;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr_i == '0) |-> (rs1_data_o == '0));

    a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2_addr_i == '0) |-> (rs2_data_o == '0));

endmodule

`default_nettype wire

// File: source/wb_stage_reg.sv
`default_nettype none

module wb_stage_reg (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire rooth_pkg::flow_e                       flow_wb_i,

    input  wire [rooth_pkg::CPU_WIDTH-1:0]              inst_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              pc_i,
    input  wire                                         reg_wr_en_i,
    input  wire [rooth_pkg::REG_ADDR_WIDTH-1:0]         reg_wr_addr_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              reg_wr_data_i,
    input  wire                                         csr_wr_en_i,
    input  wire [rooth_pkg::CSR_ADDR_WIDTH-1:0]         csr_wr_addr_i,
    input  wire [rooth_pkg::CPU_WIDTH-1:0]              csr_wr_data_i,

    output logic [rooth_pkg::CPU_WIDTH-1:0]             inst_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             pc_o,
    output logic                                        reg_wr_en_o,
    output logic [rooth_pkg::REG_ADDR_WIDTH-1:0]        reg_wr_addr_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             reg_wr_data_o,
    output logic                                        csr_wr_en_o,
    output logic [rooth_pkg::CSR_ADDR_WIDTH-1:0]        csr_wr_addr_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]             csr_wr_data_o,
    output logic                                        retire_o
);

    // ----------------------------------------
    // Stage register
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_o        <= '0;
            pc_o          <= '0;
            reg_wr_en_o   <= 1'b0;
            reg_wr_addr_o <= '0;
            reg_wr_data_o <= '0;
            csr_wr_en_o   <= 1'b0;
            csr_wr_addr_o <= '0;
            csr_wr_data_o <= '0;
            retire_o      <= 1'b0;
        end else begin
            case (flow_wb_i)
                rooth_pkg::FLOW_WORK: begin
                    inst_o        <= inst_i;
                    pc_o          <= pc_i;
                    reg_wr_en_o   <= reg_wr_en_i;
                    reg_wr_addr_o <= reg_wr_addr_i;
                    reg_wr_data_o <= reg_wr_data_i;
                    csr_wr_en_o   <= csr_wr_en_i;
                    csr_wr_addr_o <= csr_wr_addr_i;
                    csr_wr_data_o <= csr_wr_data_i;
                    // A zero word is a bubble and does not retire
                    retire_o      <= (inst_i != '0);
                end
                rooth_pkg::FLOW_STOP: begin
                    // Item held, but it must only be counted once
                    retire_o <= 1'b0;
                end
                default: begin
                    inst_o        <= '0;
                    pc_o          <= '0;
                    reg_wr_en_o   <= 1'b0;
                    reg_wr_addr_o <= '0;
                    reg_wr_data_o <= '0;
                    csr_wr_en_o   <= 1'b0;
                    csr_wr_addr_o <= '0;
                    csr_wr_data_o <= '0;
                    retire_o      <= 1'b0;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Refresh or illegal command leaves a bubble with no side effects
    a_refresh_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        !(flow_wb_i inside {rooth_pkg::FLOW_WORK, rooth_pkg::FLOW_STOP})
        |=> (!reg_wr_en_o && !csr_wr_en_o && !retire_o));

endmodule

`default_nettype wire

// File: source/rooth_pkg.sv
`default_nettype none

package rooth_pkg;

    // ----------------------------------------
    // Widths and sizes
    // ----------------------------------------

    // Data, instruction and program counter
    localparam int CPU_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_COUNT      = 32;
    localparam int CSR_ADDR_WIDTH = 12;

    // ----------------------------------------
    // Pipeline flow command
    // ----------------------------------------

    // Encoding 2'b11 is unused and treated as a refresh
    typedef enum logic [1:0] {
        FLOW_WORK    = 2'b00,
        FLOW_STOP    = 2'b01,
        FLOW_REFRESH = 2'b10
    } flow_e;

    // ----------------------------------------
    // Implemented machine CSRs
    // ----------------------------------------

    typedef enum logic [CSR_ADDR_WIDTH-1:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MINSTRET = 12'hB02
    } csr_addr_e;

endpackage

`default_nettype wire
